// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and instruction word
`define CPU_WORD_W 32

// general purpose register file
`define CPU_REG_N 16
`define CPU_REG_IDX_W 4

// main memory, word addressed
`define CPU_MEM_DEPTH 512
`define CPU_ADDR_W 9

`endif

// File: src/cpu_isa_pkg.sv
`include "cpu_consts.svh"

package cpu_isa_pkg;

	// 5-bit opcodes, gaps are shift, mul/div and branch codes not built here
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_neg  = 5'd17,
		op_not  = 5'd18,
		op_halt = 5'd31
	} opcode_e;

	typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [18:0] const_t;

	// rc sits in the top bits of the constant field
	typedef struct packed {
		reg_idx_t rc;
		logic [$bits(const_t)-`CPU_REG_IDX_W-1:0] rest;
	} rc_field_t;

	typedef union packed {
		rc_field_t rc_f;
		const_t    const_c;
	} low_field_t;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   ra;
		reg_idx_t   rb;
		low_field_t low;
	} instr_t;

endpackage

// File: src/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	// sequencer steps, one clock each
	typedef enum logic [3:0] {
		step_idle,
		step_t0,
		step_t1,
		step_t2,
		step_t3,
		step_t4,
		step_t5,
		step_t6,
		step_t7,
		step_halted
	} tstep_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_neg,
		alu_not
	} alu_op_e;

	// picks the second ALU operand and the steps after t4
	typedef enum logic [1:0] {
		class_alu_reg,
		class_alu_imm,
		class_load,
		class_store
	} iclass_e;

endpackage

// File: src/control_seq.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module control_seq (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic                   load_en,
	input  cpu_ctrl_pkg::iclass_e  iclass,
	input  logic                   is_halt,
	input  logic [`CPU_WORD_W-1:0] z_value,
	output logic [`CPU_ADDR_W-1:0] mem_addr,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic                   ir_en,
	output logic                   y_en,
	output logic                   z_en,
	output logic                   wb_en,
	output logic                   wb_from_mem,
	output logic                   halted
);
	cpu_ctrl_pkg::tstep_e step;
	cpu_ctrl_pkg::tstep_e step_next;
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_ADDR_W-1:0] mar;
	logic is_load;
	logic is_store;
	logic mem_class;
	logic mar_from_z;
	logic run_start;

	assign is_load = (iclass == cpu_ctrl_pkg::class_load);
	assign is_store = (iclass == cpu_ctrl_pkg::class_store);
	assign mem_class = is_load | is_store;

	// start only from a stopped core, never while the load port is busy
	assign run_start = start & ~load_en &
		(step == cpu_ctrl_pkg::step_idle || step == cpu_ctrl_pkg::step_halted);

	always_comb begin
		step_next = step;
		case (step)
			cpu_ctrl_pkg::step_idle,
			cpu_ctrl_pkg::step_halted: if (run_start) step_next = cpu_ctrl_pkg::step_t0;
			cpu_ctrl_pkg::step_t0: step_next = cpu_ctrl_pkg::step_t1;
			cpu_ctrl_pkg::step_t1: step_next = cpu_ctrl_pkg::step_t2;
			cpu_ctrl_pkg::step_t2: step_next = cpu_ctrl_pkg::step_t3;
			cpu_ctrl_pkg::step_t3: step_next = is_halt ? cpu_ctrl_pkg::step_halted :
				cpu_ctrl_pkg::step_t4;
			cpu_ctrl_pkg::step_t4: step_next = cpu_ctrl_pkg::step_t5;
			cpu_ctrl_pkg::step_t5: step_next = mem_class ? cpu_ctrl_pkg::step_t6 :
				cpu_ctrl_pkg::step_t0;
			cpu_ctrl_pkg::step_t6: step_next = is_load ? cpu_ctrl_pkg::step_t7 :
				cpu_ctrl_pkg::step_t0;
			cpu_ctrl_pkg::step_t7: step_next = cpu_ctrl_pkg::step_t0;
			default: step_next = cpu_ctrl_pkg::step_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= cpu_ctrl_pkg::step_idle;
			pc <= '0;
			mar <= '0;
		end else begin
			step <= step_next;
			if (run_start)
				pc <= '0;
			else if (step == cpu_ctrl_pkg::step_t0)
				pc <= pc + 1'b1;
			// fetch address at t0, effective address at t5
			if (step == cpu_ctrl_pkg::step_t0)
				mar <= pc;
			else if (mar_from_z)
				mar <= z_value[`CPU_ADDR_W-1:0];
		end
	end

	always_comb begin
		mem_read = 1'b0;
		mem_write = 1'b0;
		ir_en = 1'b0;
		y_en = 1'b0;
		z_en = 1'b0;
		wb_en = 1'b0;
		wb_from_mem = 1'b0;
		mar_from_z = 1'b0;
		case (step)
			cpu_ctrl_pkg::step_t1: mem_read = 1'b1;
			cpu_ctrl_pkg::step_t2: ir_en = 1'b1;
			cpu_ctrl_pkg::step_t3: y_en = ~is_halt;
			cpu_ctrl_pkg::step_t4: z_en = 1'b1;
			cpu_ctrl_pkg::step_t5: begin
				wb_en = ~mem_class;
				mar_from_z = mem_class;
			end
			cpu_ctrl_pkg::step_t6: begin
				mem_read = is_load;
				mem_write = is_store;
			end
			cpu_ctrl_pkg::step_t7: begin
				wb_en = 1'b1;
				wb_from_mem = 1'b1;
			end
			default: ;
		endcase
	end

	assign mem_addr = mar;
	assign halted = (step == cpu_ctrl_pkg::step_halted);

endmodule

// File: src/ir_decode.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module ir_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ir_en,
	input  logic [`CPU_WORD_W-1:0] mem_data,
	output cpu_isa_pkg::reg_idx_t  ra,
	output cpu_isa_pkg::reg_idx_t  rb,
	output cpu_isa_pkg::reg_idx_t  rc,
	output logic [`CPU_WORD_W-1:0] const_ext,
	output cpu_ctrl_pkg::alu_op_e  alu_op,
	output cpu_ctrl_pkg::iclass_e  iclass,
	output logic                   is_halt
);
	localparam int pad_w = `CPU_WORD_W - $bits(cpu_isa_pkg::const_t);

	cpu_isa_pkg::instr_t ir;

	always_ff @(posedge clk) begin
		if (rst)
			ir <= '0;
		else if (ir_en)
			ir <= mem_data;
	end

	assign ra = ir.ra;
	assign rb = ir.rb;
	assign rc = ir.low.rc_f.rc;
	assign const_ext = {{pad_w{ir.low.const_c[$bits(cpu_isa_pkg::const_t)-1]}}, ir.low.const_c};
	assign is_halt = (ir.opcode == cpu_isa_pkg::op_halt);

	// ld, ldi and st all form base plus constant
	always_comb begin
		alu_op = cpu_ctrl_pkg::alu_add;
		iclass = cpu_ctrl_pkg::class_alu_reg;
		case (ir.opcode)
			cpu_isa_pkg::op_ld:   iclass = cpu_ctrl_pkg::class_load;
			cpu_isa_pkg::op_st:   iclass = cpu_ctrl_pkg::class_store;
			cpu_isa_pkg::op_ldi,
			cpu_isa_pkg::op_addi: iclass = cpu_ctrl_pkg::class_alu_imm;
			cpu_isa_pkg::op_sub:  alu_op = cpu_ctrl_pkg::alu_sub;
			cpu_isa_pkg::op_and:  alu_op = cpu_ctrl_pkg::alu_and;
			cpu_isa_pkg::op_or:   alu_op = cpu_ctrl_pkg::alu_or;
			cpu_isa_pkg::op_andi: begin
				alu_op = cpu_ctrl_pkg::alu_and;
				iclass = cpu_ctrl_pkg::class_alu_imm;
			end
			cpu_isa_pkg::op_ori: begin
				alu_op = cpu_ctrl_pkg::alu_or;
				iclass = cpu_ctrl_pkg::class_alu_imm;
			end
			cpu_isa_pkg::op_neg:  alu_op = cpu_ctrl_pkg::alu_neg;
			cpu_isa_pkg::op_not:  alu_op = cpu_ctrl_pkg::alu_not;
			default: ;
		endcase
	end

endmodule

// File: src/alu_exec.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module alu_exec (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   y_en,
	input  logic                   z_en,
	input  logic [`CPU_WORD_W-1:0] base_data,
	input  logic [`CPU_WORD_W-1:0] rc_data,
	input  logic [`CPU_WORD_W-1:0] const_ext,
	input  cpu_ctrl_pkg::alu_op_e  alu_op,
	input  cpu_ctrl_pkg::iclass_e  iclass,
	output logic [`CPU_WORD_W-1:0] z_value
);
	logic [`CPU_WORD_W-1:0] y;
	logic [`CPU_WORD_W-1:0] z;
	logic [`CPU_WORD_W-1:0] operand;
	logic [`CPU_WORD_W-1:0] result;

	// register operand only for alu_reg, every other class uses the constant
	assign operand = (iclass == cpu_ctrl_pkg::class_alu_reg) ? rc_data : const_ext;

	always_comb begin
		case (alu_op)
			cpu_ctrl_pkg::alu_sub: result = y - operand;
			cpu_ctrl_pkg::alu_and: result = y & operand;
			cpu_ctrl_pkg::alu_or:  result = y | operand;
			cpu_ctrl_pkg::alu_neg: result = -y;
			cpu_ctrl_pkg::alu_not: result = ~y;
			default:               result = y + operand;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			y <= '0;
			z <= '0;
		end else begin
			if (y_en)
				y <= base_data;
			if (z_en)
				z <= result;
		end
	end

	assign z_value = z;

endmodule

// File: src/reg_result.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module reg_result (
	input  logic                   clk,
	input  logic                   rst,
	input  cpu_isa_pkg::reg_idx_t  ra,
	input  cpu_isa_pkg::reg_idx_t  rb,
	input  cpu_isa_pkg::reg_idx_t  rc,
	input  logic                   wb_en,
	input  logic                   wb_from_mem,
	input  logic [`CPU_WORD_W-1:0] z_value,
	input  logic [`CPU_WORD_W-1:0] mem_data,
	output logic [`CPU_WORD_W-1:0] base_data,
	output logic [`CPU_WORD_W-1:0] rc_data,
	output logic [`CPU_WORD_W-1:0] store_data,
	output logic                   wr_en,
	output cpu_isa_pkg::reg_idx_t  wr_idx,
	output logic [`CPU_WORD_W-1:0] wr_data
);
	logic [`CPU_WORD_W-1:0] regs [`CPU_REG_N];
	logic [`CPU_WORD_W-1:0] wdata;

	assign wdata = wb_from_mem ? mem_data : z_value;

	// r0 as base gives absolute addressing
	assign base_data = (rb == '0) ? '0 : regs[rb];
	assign rc_data = regs[rc];
	assign store_data = regs[ra];

	always_ff @(posedge clk) begin
		if (wb_en)
			regs[ra] <= wdata;
	end

	// write event trails the file update by one clock
	always_ff @(posedge clk) begin
		if (rst)
			wr_en <= 1'b0;
		else
			wr_en <= wb_en;
	end

	always_ff @(posedge clk) begin
		if (wb_en) begin
			wr_idx <= ra;
			wr_data <= wdata;
		end
	end

endmodule

// File: src/main_mem.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module main_mem (
	input  logic                   clk,
	input  logic [`CPU_ADDR_W-1:0] addr,
	input  logic                   read,
	input  logic                   write,
	input  logic [`CPU_WORD_W-1:0] wdata,
	input  logic                   load_en,
	input  logic [`CPU_ADDR_W-1:0] load_addr,
	input  logic [`CPU_WORD_W-1:0] load_data,
	output logic [`CPU_WORD_W-1:0] rdata
);
	logic [`CPU_WORD_W-1:0] mem [`CPU_MEM_DEPTH];

	// load port wins over a core write
	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_addr] <= load_data;
		else if (write)
			mem[addr] <= wdata;
	end

	// rdata valid the clock after read
	always_ff @(posedge clk) begin
		if (read)
			rdata <= mem[addr];
	end

endmodule

// File: src/cpu_core.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_core (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic                   load_en,
	input  logic [`CPU_ADDR_W-1:0] load_addr,
	input  logic [`CPU_WORD_W-1:0] load_data,
	output logic                   wr_en,
	output cpu_isa_pkg::reg_idx_t  wr_idx,
	output logic [`CPU_WORD_W-1:0] wr_data,
	output logic                   st_en,
	output logic [`CPU_ADDR_W-1:0] st_addr,
	output logic [`CPU_WORD_W-1:0] st_data,
	output logic                   halted
);
	logic [`CPU_ADDR_W-1:0] mem_addr;
	logic                   mem_read;
	logic                   mem_write;
	logic [`CPU_WORD_W-1:0] mem_rdata;
	logic                   ir_en;
	logic                   y_en;
	logic                   z_en;
	logic                   wb_en;
	logic                   wb_from_mem;
	cpu_isa_pkg::reg_idx_t  ra;
	cpu_isa_pkg::reg_idx_t  rb;
	cpu_isa_pkg::reg_idx_t  rc;
	logic [`CPU_WORD_W-1:0] const_ext;
	cpu_ctrl_pkg::alu_op_e  alu_op;
	cpu_ctrl_pkg::iclass_e  iclass;
	logic                   is_halt;
	logic [`CPU_WORD_W-1:0] z_value;
	logic [`CPU_WORD_W-1:0] base_data;
	logic [`CPU_WORD_W-1:0] rc_data;
	logic [`CPU_WORD_W-1:0] store_data;

	control_seq i_control_seq (.clk, .rst, .start, .load_en, .iclass, .is_halt, .z_value,
		.mem_addr, .mem_read, .mem_write, .ir_en, .y_en, .z_en, .wb_en, .wb_from_mem,
		.halted);

	ir_decode i_ir_decode (.clk, .rst, .ir_en, .mem_data(mem_rdata), .ra, .rb, .rc,
		.const_ext, .alu_op, .iclass, .is_halt);

	alu_exec i_alu_exec (.clk, .rst, .y_en, .z_en, .base_data, .rc_data, .const_ext,
		.alu_op, .iclass, .z_value);

	reg_result i_reg_result (.clk, .rst, .ra, .rb, .rc, .wb_en, .wb_from_mem, .z_value,
		.mem_data(mem_rdata), .base_data, .rc_data, .store_data, .wr_en, .wr_idx, .wr_data);

	main_mem i_main_mem (.clk, .addr(mem_addr), .read(mem_read), .write(mem_write),
		.wdata(store_data), .load_en, .load_addr, .load_data, .rdata(mem_rdata));

	// store event mirrors the core side memory write
	assign st_en = mem_write;
	assign st_addr = mem_addr;
	assign st_data = store_data;

endmodule

// File: verif/cpu_chk.sv
`timescale 1ns/10ps

module cpu_chk (
	input logic clk,
	input logic rst,
	input logic start,
	input logic mem_read,
	input logic mem_write,
	input logic ir_en,
	input logic y_en,
	input logic z_en,
	input logic wb_en,
	input logic wr_en,
	input logic st_en,
	input logic halted
);
	logic started;
	logic any_strobe;
	int   fail_count = 0;

	assign any_strobe = mem_read | mem_write | ir_en | y_en | z_en | wb_en | wr_en | st_en;

	// first start after reset
	always_ff @(posedge clk) begin
		if (rst)
			started <= 1'b0;
		else if (start)
			started <= 1'b1;
	end

	event_excl: assert property (@(posedge clk) disable iff (rst) !(wr_en && st_en))
		else begin
			fail_count++;
			$error("register write and store in the same cycle");
		end

	halt_hold: assert property (@(posedge clk) disable iff (rst) halted && !start |=> halted)
		else begin
			fail_count++;
			$error("halted dropped without a start");
		end

	quiet_before_start: assert property (@(posedge clk) disable iff (rst) !started |-> !any_strobe)
		else begin
			fail_count++;
			$error("datapath strobe before the first start");
		end

endmodule

bind cpu_core cpu_chk i_cpu_chk (.clk, .rst, .start, .mem_read, .mem_write, .ir_en, .y_en,
	.z_en, .wb_en, .wr_en, .st_en, .halted);

// File: verif/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_tb;
	localparam int period_ns = 100;

	typedef struct packed {
		logic                   is_store;
		logic [`CPU_ADDR_W-1:0] where;
		logic [`CPU_WORD_W-1:0] data;
	} event_t;

	logic                   clk;
	logic                   rst;
	logic                   start;
	logic                   load_en;
	logic [`CPU_ADDR_W-1:0] load_addr;
	logic [`CPU_WORD_W-1:0] load_data;
	logic                   wr_en;
	cpu_isa_pkg::reg_idx_t  wr_idx;
	logic [`CPU_WORD_W-1:0] wr_data;
	logic                   st_en;
	logic [`CPU_ADDR_W-1:0] st_addr;
	logic [`CPU_WORD_W-1:0] st_data;
	logic                   halted;

	logic [31:0]            rng;
	logic [`CPU_WORD_W-1:0] prog [$];
	logic [`CPU_WORD_W-1:0] model_regs [`CPU_REG_N];
	logic [`CPU_WORD_W-1:0] model_mem [`CPU_MEM_DEPTH];
	event_t                 exp_q [$];
	int                     exp_wr;
	int                     exp_st;
	int                     seen_wr;
	int                     seen_st;
	int                     checks;
	int                     errors;
	bit                     prog_ready;

	cpu_core i_cpu_core (.clk, .rst, .start, .load_en, .load_addr, .load_data, .wr_en, .wr_idx,
		.wr_data, .st_en, .st_addr, .st_data, .halted);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	// r0 is never written by the program
	function automatic cpu_isa_pkg::reg_idx_t pick_reg();
		return cpu_isa_pkg::reg_idx_t'(rand_word() % 15 + 1);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// reference model, one instruction at a time
	function automatic void ref_exec(input logic [`CPU_WORD_W-1:0] instr);
		cpu_isa_pkg::opcode_e   op;
		cpu_isa_pkg::reg_idx_t  ra;
		cpu_isa_pkg::reg_idx_t  rb;
		cpu_isa_pkg::reg_idx_t  rc;
		logic [`CPU_WORD_W-1:0] base;
		logic [`CPU_WORD_W-1:0] cval;
		logic [`CPU_WORD_W-1:0] res;
		logic [`CPU_ADDR_W-1:0] addr;
		event_t                 ev;
		op = cpu_isa_pkg::opcode_e'(instr[31:27]);
		ra = instr[26:23];
		rb = instr[22:19];
		rc = instr[18:15];
		cval = {{13{instr[18]}}, instr[18:0]};
		base = (rb == 4'd0) ? 32'd0 : model_regs[rb];
		// ld, ldi, st and addi all start from base plus constant
		res = base + cval;
		addr = res[`CPU_ADDR_W-1:0];
		case (op)
			cpu_isa_pkg::op_ld:   res = model_mem[addr];
			cpu_isa_pkg::op_add:  res = base + model_regs[rc];
			cpu_isa_pkg::op_sub:  res = base - model_regs[rc];
			cpu_isa_pkg::op_and:  res = base & model_regs[rc];
			cpu_isa_pkg::op_or:   res = base | model_regs[rc];
			cpu_isa_pkg::op_andi: res = base & cval;
			cpu_isa_pkg::op_ori:  res = base | cval;
			cpu_isa_pkg::op_neg:  res = 32'd0 - base;
			cpu_isa_pkg::op_not:  res = ~base;
			default: ;
		endcase
		if (op == cpu_isa_pkg::op_st) begin
			ev.is_store = 1'b1;
			ev.where = addr;
			ev.data = model_regs[ra];
			model_mem[addr] = model_regs[ra];
			exp_q.push_back(ev);
			exp_st++;
		end else if (op != cpu_isa_pkg::op_halt) begin
			ev.is_store = 1'b0;
			ev.where = `CPU_ADDR_W'(ra);
			ev.data = res;
			model_regs[ra] = res;
			exp_q.push_back(ev);
			exp_wr++;
		end
	endfunction

	function automatic void emit(input cpu_isa_pkg::opcode_e op, input cpu_isa_pkg::reg_idx_t ra,
		input cpu_isa_pkg::reg_idx_t rb, input logic [18:0] c);
		logic [`CPU_WORD_W-1:0] word;
		word = {op, ra, rb, c};
		prog.push_back(word);
		ref_exec(word);
	endfunction

	function automatic void build_program();
		cpu_isa_pkg::opcode_e  op;
		cpu_isa_pkg::reg_idx_t rd;
		logic [18:0]           c;
		// odd registers get negative constants
		for (int i = 1; i < `CPU_REG_N; i++) begin
			c = 19'(rand_word());
			if (i % 2 == 1)
				c[18] = 1'b1;
			emit(cpu_isa_pkg::op_ldi, 4'(i), 4'd0, c);
		end
		// two negative operands so the carry out is dropped
		emit(cpu_isa_pkg::op_add, 4'd2, 4'd1, {4'd3, 15'd0});
		for (int i = 0; i < 12; i++) begin
			case (i % 4)
				0: op = cpu_isa_pkg::op_add;
				1: op = cpu_isa_pkg::op_sub;
				2: op = cpu_isa_pkg::op_and;
				default: op = cpu_isa_pkg::op_or;
			endcase
			emit(op, pick_reg(), pick_reg(), {pick_reg(), 15'd0});
		end
		for (int i = 0; i < 10; i++) begin
			case (i % 5)
				0: op = cpu_isa_pkg::op_addi;
				1: op = cpu_isa_pkg::op_andi;
				2: op = cpu_isa_pkg::op_ori;
				3: op = cpu_isa_pkg::op_neg;
				default: op = cpu_isa_pkg::op_not;
			endcase
			emit(op, pick_reg(), pick_reg(), 19'(rand_word()));
		end
		emit(cpu_isa_pkg::op_ldi, 4'd14, 4'd0, 19'd0);
		emit(cpu_isa_pkg::op_neg, 4'd13, 4'd14, 19'd0);
		// data area above the program with r5 as base
		emit(cpu_isa_pkg::op_ldi, 4'd5, 4'd0, 19'd256);
		for (int i = 0; i < 4; i++) begin
			c = 19'(rand_word() % 64);
			rd = pick_reg();
			if (rd == 4'd5)
				rd = 4'd6;
			emit(cpu_isa_pkg::op_st, pick_reg(), 4'd5, c);
			emit(cpu_isa_pkg::op_ld, rd, 4'd5, c);
		end
		emit(cpu_isa_pkg::op_st, pick_reg(), 4'd0, 19'd300);
		emit(cpu_isa_pkg::op_ld, 4'd9, 4'd0, 19'd300);
		emit(cpu_isa_pkg::op_halt, 4'd0, 4'd0, 19'd0);
	endfunction

	always @(negedge clk) begin : compare_events
		event_t e;
		if (!rst && (wr_en || st_en)) begin
			if (wr_en)
				seen_wr++;
			else
				seen_st++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("unexpected %s event at %0t, no event was predicted",
					wr_en ? "register write" : "store", $time);
			end else begin
				e = exp_q.pop_front();
				check_value("event kind", 32'(st_en), 32'(e.is_store));
				if (wr_en) begin
					check_value("wr_idx", 32'(wr_idx), 32'(e.where));
					check_value("wr_data", wr_data, e.data);
				end else begin
					check_value("st_addr", 32'(st_addr), 32'(e.where));
					check_value("st_data", st_data, e.data);
				end
			end
		end
	end

	initial begin
		rng = 32'h5709_5820;
		rst = 1'b1;
		start = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		exp_wr = 0;
		exp_st = 0;
		seen_wr = 0;
		seen_st = 0;
		checks = 0;
		errors = 0;
		build_program();
		prog_ready = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		foreach (prog[i]) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= `CPU_ADDR_W'(i);
			load_data <= prog[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!halted)
			@(negedge clk);
		// quiet window where nothing may follow halt
		repeat (20) @(negedge clk);
		check_value("write count", 32'(seen_wr), 32'(exp_wr));
		check_value("store count", 32'(seen_st), 32'(exp_st));
		check_value("pending events", 32'(exp_q.size()), 32'd0);
		check_value("assertion failures", 32'(i_cpu_core.i_cpu_chk.fail_count), 32'd0);
		$display("%0d checks, %0d errors, %0d writes, %0d stores",
			checks, errors, seen_wr, seen_st);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// budget of 8 cycles and one load cycle per instruction plus reset and margin
	initial begin
		wait (prog_ready);
		#((prog.size() * (8 + 1) + 200) * period_ns);
		$display("timeout, the core did not halt in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: sources.f
+incdir+include
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/control_seq.sv
src/ir_decode.sv
src/alu_exec.sv
src/reg_result.sv
src/main_mem.sv
src/cpu_core.sv
verif/cpu_chk.sv
verif/cpu_tb.sv

// File: Makefile
# Verilator simulation of the multi-cycle core

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: sim clean

# pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
